// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= link_test_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Checks failed

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/link_test_tb.sv
`timescale 1ns/1ns
`default_nettype none

module link_test_tb;

  logic        CLK;
  logic        RSTX;
  logic        clr;
  logic        hold;
  logic [7:0]  mode;
  logic [1:0]  lane_sel;
  logic [7:0]  din;
  logic [7:0]  dout;
  logic [7:0]  flip_mask;
  logic [31:0] recv_cnt;
  logic [31:0] err_cnt;
  logic [3:0]  err_flags;

  int          num_tests;
  int          num_checks;
  int          num_errors;
  int          test_start_errors;

  assign din = dout ^ flip_mask;  // Loopback with bit-flip injection

  link_test_top u_dut (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .clr       (clr),
    .hold      (hold),
    .mode      (mode),
    .lane_sel  (lane_sel),
    .din       (din),
    .dout      (dout),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .err_flags (err_flags)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    num_checks++;
    if (actual !== expected) begin
      num_errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic test_done(input string name);
    num_tests++;
    $display("Test %s finished with %0d errors", name, num_errors - test_start_errors);
    test_start_errors = num_errors;
  endtask

  // New mode and a counter clear
  task automatic restart(input logic [7:0] m);
    hold = 1'b0;
    mode = m;
    clr  = 1'b1;
    repeat (3) tick();
    clr  = 1'b0;
  endtask

  task automatic start_hold();
    hold = 1'b1;
    repeat (4) tick();
  endtask

  task automatic read_lane(input int lane, output logic [31:0] recv, output logic [31:0] err);
    lane_sel = 2'(lane);
    repeat (2) tick();  // Result is registered
    recv = recv_cnt;
    err  = err_cnt;
  endtask

  task automatic wait_counting(input int lane);
    int n;
    lane_sel = 2'(lane);
    n = 0;
    while (recv_cnt == 0 && n < 50) begin
      tick();
      n++;
    end
    if (recv_cnt == 0) begin
      num_errors++;
      $display("Timeout at %0t ns: lane %0d never started counting", $time, lane);
    end
  endtask

  task automatic flip_once(input int lane);
    int bit_idx;
    bit_idx = $urandom % 2;
    flip_mask[lane*2 + bit_idx] = 1'b1;
    tick();
    flip_mask = '0;
    repeat (10) tick();  // Let delayed PRBS errors settle
  endtask

  initial begin
    logic [31:0] recv;
    logic [31:0] err;
    logic [31:0] first_recv [4];
    int          k;

    RSTX      = 1'b0;
    clr       = 1'b0;
    hold      = 1'b0;
    mode      = 8'h00;
    lane_sel  = 2'd0;
    flip_mask = '0;
    num_tests = 0;
    num_checks = 0;
    num_errors = 0;
    test_start_errors = 0;
    void'($urandom(32'h3aabf395));
    repeat (4) @(posedge CLK);
    #1;
    RSTX = 1'b1;
    tick();

    check("dout", 32'(dout), 32'd0);
    check("recv_cnt", recv_cnt, 32'd0);
    check("err_cnt", err_cnt, 32'd0);
    check("err_flags", 32'(err_flags), 32'd0);
    test_done("reset");

    restart(8'h1F);  // PRBS7 on all lanes
    wait_counting(0);
    repeat (200) tick();
    start_hold();
    for (int i = 0; i < 4; i++) begin
      read_lane(i, recv, err);
      check($sformatf("recv_cnt nonzero lane %0d", i), 32'(recv != 0), 32'd1);
      check($sformatf("err_cnt lane %0d", i), err, 32'd0);
      first_recv[i] = recv;
    end
    check("err_flags", 32'(err_flags), 32'd0);
    repeat (5) tick();
    for (int i = 0; i < 4; i++) begin
      read_lane(i, recv, err);
      check($sformatf("held recv_cnt lane %0d", i), recv, first_recv[i]);
    end
    test_done("prbs_clean");

    restart(8'h1F);
    wait_counting(2);
    k = 2 + int'($urandom % 3);
    for (int i = 0; i < k; i++) flip_once(2);
    start_hold();
    for (int i = 0; i < 4; i++) begin
      read_lane(i, recv, err);
      check($sformatf("err_cnt lane %0d", i), err, (i == 2) ? 32'(3 * k) : 32'd0);
    end
    check("err_flags", 32'(err_flags), 32'h4);
    test_done("prbs_flips");

    restart(8'h2F);  // ALT pattern
    wait_counting(1);
    for (int i = 0; i < k; i++) flip_once(1);
    start_hold();
    read_lane(1, recv, err);
    check("err_cnt lane 1 alt", err, 32'(k));
    mode = 8'h3F;  // Mode change alone clears the lanes
    repeat (4) tick();
    read_lane(1, recv, err);
    check("recv_cnt lane 1 after mode change", recv, 32'd0);
    check("err_cnt lane 1 after mode change", err, 32'd0);
    hold = 1'b0;
    wait_counting(1);
    for (int i = 0; i < k; i++) flip_once(1);
    start_hold();
    read_lane(1, recv, err);
    check("err_cnt lane 1 ramp", err, 32'(k));
    test_done("alt_ramp");

    restart(8'h13);  // Lanes 0 and 1 only
    wait_counting(0);
    for (int i = 0; i < 8; i++) begin
      tick();
      check("dout lanes 3 and 2", 32'(dout[7:4]), 32'd0);
    end
    start_hold();
    for (int i = 0; i < 4; i++) begin
      read_lane(i, recv, err);
      check($sformatf("recv_cnt active lane %0d", i), 32'(recv != 0), 32'(i < 2));
      check($sformatf("err_cnt lane %0d", i), err, 32'd0);
    end
    clr = 1'b1;
    repeat (3) tick();
    for (int i = 0; i < 4; i++) begin
      read_lane(i, recv, err);
      check($sformatf("cleared recv_cnt lane %0d", i), recv, 32'd0);
      check($sformatf("cleared err_cnt lane %0d", i), err, 32'd0);
    end
    clr = 1'b0;
    test_done("lane_mask");

    $display("Tests %0d, checks %0d, errors %0d", num_tests, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/link_test_pkg.sv
`default_nettype none

package link_test_pkg;

  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 2;  // Dibit lanes
  localparam int CNT_W     = 32;

  // Samples ignored after a clear, enough to fill the PRBS7 history
  localparam int                WARM_W = 3;
  localparam logic [WARM_W-1:0] WARMUP = WARM_W'(4);

  localparam int                PRBS_W    = 7;
  localparam logic [PRBS_W-1:0] PRBS_SEED = '1;
  localparam logic [LANE_W-1:0] ALT_DIBIT = 2'b10;

  // Opcode in mode[7:4], unlisted codes behave as idle
  typedef enum logic [3:0] {
    OP_IDLE  = 4'd0,
    OP_PRBS7 = 4'd1,
    OP_ALT   = 4'd2,
    OP_RAMP  = 4'd3
  } link_op_e;

  typedef enum logic [1:0] {
    PAT_PRBS7 = 2'd0,  // x^7 + x^6 + 1
    PAT_ALT   = 2'd1,
    PAT_RAMP  = 2'd2
  } pattern_e;

endpackage

`default_nettype wire

// File: rtl/link_test_top.sv
`timescale 1ns/1ns
`default_nettype none

module link_test_top (
  input  wire                                                       CLK,
  input  wire                                                       RSTX,
  input  wire                                                       clr,
  input  wire                                                       hold,
  input  wire  [7:0]                                                mode,
  input  wire  [1:0]                                                lane_sel,
  input  wire  [link_test_pkg::NUM_LANES*link_test_pkg::LANE_W-1:0] din,
  output logic [link_test_pkg::NUM_LANES*link_test_pkg::LANE_W-1:0] dout,
  output logic [link_test_pkg::CNT_W-1:0]                           recv_cnt,
  output logic [link_test_pkg::CNT_W-1:0]                           err_cnt,
  output logic [link_test_pkg::NUM_LANES-1:0]                       err_flags
);

  link_test_pkg::pattern_e                                   pattern;
  logic [link_test_pkg::NUM_LANES-1:0]                       lane_en;
  logic                                                      lane_clr;
  logic                                                      chk_clr;
  logic [link_test_pkg::NUM_LANES*link_test_pkg::CNT_W-1:0]  recv_all;
  logic [link_test_pkg::NUM_LANES*link_test_pkg::CNT_W-1:0]  err_all;

  assign chk_clr = clr || lane_clr;  // Counters also restart on a mode change

  mode_decoder u_mode (
    .CLK      (CLK),
    .RSTX     (RSTX),
    .mode     (mode),
    .pattern  (pattern),
    .lane_en  (lane_en),
    .lane_clr (lane_clr)
  );

  for (genvar i = 0; i < link_test_pkg::NUM_LANES; i++) begin : g_lane
    pattern_gen u_gen (
      .CLK     (CLK),
      .RSTX    (RSTX),
      .en      (lane_en[i]),
      .clr     (lane_clr),
      .pattern (pattern),
      .dout    (dout[i*link_test_pkg::LANE_W +: link_test_pkg::LANE_W])
    );

    pattern_check u_chk (
      .CLK      (CLK),
      .RSTX     (RSTX),
      .en       (lane_en[i]),
      .clr      (chk_clr),
      .hold     (hold),
      .pattern  (pattern),
      .din      (din[i*link_test_pkg::LANE_W +: link_test_pkg::LANE_W]),
      .recv_cnt (recv_all[i*link_test_pkg::CNT_W +: link_test_pkg::CNT_W]),
      .err_cnt  (err_all[i*link_test_pkg::CNT_W +: link_test_pkg::CNT_W])
    );
  end

  result_select u_res (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .lane_sel  (lane_sel),
    .recv_all  (recv_all),
    .err_all   (err_all),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .err_flags (err_flags)
  );

endmodule

`default_nettype wire

// File: rtl/mode_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mode_decoder (
  input  wire                                   CLK,
  input  wire                                   RSTX,
  input  wire  [7:0]                            mode,
  output link_test_pkg::pattern_e               pattern,
  output logic [link_test_pkg::NUM_LANES-1:0]   lane_en,
  output logic                                  lane_clr
);

  logic [7:0]                          mode_q;
  link_test_pkg::pattern_e             pat_d;
  logic [link_test_pkg::NUM_LANES-1:0] en_d;

  always_comb begin
    pat_d = link_test_pkg::PAT_PRBS7;
    en_d  = mode[link_test_pkg::NUM_LANES-1:0];
    case (link_test_pkg::link_op_e'(mode[7:4]))
      link_test_pkg::OP_PRBS7: pat_d = link_test_pkg::PAT_PRBS7;
      link_test_pkg::OP_ALT:   pat_d = link_test_pkg::PAT_ALT;
      link_test_pkg::OP_RAMP:  pat_d = link_test_pkg::PAT_RAMP;
      default:                 en_d  = '0;  // Idle and unused codes
    endcase
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      mode_q   <= '0;
      pattern  <= link_test_pkg::PAT_PRBS7;
      lane_en  <= '0;
      lane_clr <= 1'b1;  // Lanes start from a clean state
    end else begin
      mode_q   <= mode;
      pattern  <= pat_d;
      lane_en  <= en_d;
      lane_clr <= (mode != mode_q);
    end
  end

  a_idle_no_lanes: assert property (
    @(posedge CLK) disable iff (!RSTX)
    !(mode_q[7:4] inside {link_test_pkg::OP_PRBS7, link_test_pkg::OP_ALT,
                          link_test_pkg::OP_RAMP})
      |-> (lane_en == '0)
  );

endmodule

`default_nettype wire

// File: rtl/pattern_check.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_check (
  input  wire                               CLK,
  input  wire                               RSTX,
  input  wire                               en,
  input  wire                               clr,
  input  wire                               hold,
  input  link_test_pkg::pattern_e           pattern,
  input  wire  [link_test_pkg::LANE_W-1:0]  din,
  output logic [link_test_pkg::CNT_W-1:0]   recv_cnt,
  output logic [link_test_pkg::CNT_W-1:0]   err_cnt
);

  logic [link_test_pkg::WARM_W-1:0] warm_q;
  logic [link_test_pkg::PRBS_W-1:0] hist_q;
  logic [link_test_pkg::LANE_W-1:0] ramp_q;
  logic [link_test_pkg::LANE_W-1:0] expect_d;
  logic [link_test_pkg::LANE_W-1:0] diff;
  logic [1:0]                       nerr;
  logic                             counting;

  assign counting = en && !clr && (warm_q == link_test_pkg::WARMUP);

  always_comb begin
    case (pattern)
      // Predicted from received bits, so a flip shows up three times
      link_test_pkg::PAT_PRBS7: expect_d = {hist_q[6] ^ hist_q[5], hist_q[5] ^ hist_q[4]};
      link_test_pkg::PAT_ALT:   expect_d = link_test_pkg::ALT_DIBIT;
      link_test_pkg::PAT_RAMP:  expect_d = ramp_q;
      default:                  expect_d = din;
    endcase
    diff = din ^ expect_d;
    nerr = {1'b0, diff[1]} + {1'b0, diff[0]};  // 0 to 2 bad bits
  end

  always_ff @(posedge CLK) begin
    hist_q <= {hist_q[4:0], din};
    ramp_q <= counting ? ramp_q + 2'd1 : din + 2'd1;  // Last warm-up sample seeds ramp
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      warm_q   <= '0;
      recv_cnt <= '0;
      err_cnt  <= '0;
    end else if (clr || !en) begin
      warm_q   <= '0;
      recv_cnt <= '0;
      err_cnt  <= '0;
    end else if (warm_q != link_test_pkg::WARMUP) begin
      warm_q <= warm_q + {{(link_test_pkg::WARM_W-1){1'b0}}, 1'b1};
    end else if (!hold) begin
      recv_cnt <= recv_cnt + {{(link_test_pkg::CNT_W-1){1'b0}}, 1'b1};
      err_cnt  <= err_cnt + {{(link_test_pkg::CNT_W-2){1'b0}}, nerr};
    end
  end

  a_err_bound: assert property (
    @(posedge CLK) disable iff (!RSTX)
    {1'b0, err_cnt} <= {recv_cnt, 1'b0}
  );

endmodule

`default_nettype wire

// File: rtl/pattern_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_gen (
  input  wire                                CLK,
  input  wire                                RSTX,
  input  wire                                en,
  input  wire                                clr,
  input  link_test_pkg::pattern_e            pattern,
  output logic [link_test_pkg::LANE_W-1:0]   dout
);

  logic [link_test_pkg::PRBS_W-1:0] prbs_q;
  logic [link_test_pkg::PRBS_W-1:0] prbs_src;
  logic [link_test_pkg::LANE_W-1:0] prbs_bits;
  logic [link_test_pkg::LANE_W-1:0] ramp_q;
  logic [link_test_pkg::LANE_W-1:0] ramp_src;

  // A clear restarts from the seed in the same cycle
  always_comb begin
    prbs_src  = clr ? link_test_pkg::PRBS_SEED : prbs_q;
    ramp_src  = clr ? '0 : ramp_q;
    prbs_bits = {prbs_src[6] ^ prbs_src[5], prbs_src[5] ^ prbs_src[4]};  // Older bit on top
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      prbs_q <= link_test_pkg::PRBS_SEED;
      ramp_q <= '0;
      dout   <= '0;
    end else if (!en) begin
      prbs_q <= link_test_pkg::PRBS_SEED;
      ramp_q <= '0;
      dout   <= '0;
    end else begin
      prbs_q <= prbs_src;
      ramp_q <= ramp_src;
      case (pattern)
        link_test_pkg::PAT_PRBS7: begin
          prbs_q <= {prbs_src[4:0], prbs_bits};  // Two steps per cycle
          dout   <= prbs_bits;
        end
        link_test_pkg::PAT_ALT:  dout <= link_test_pkg::ALT_DIBIT;
        link_test_pkg::PAT_RAMP: begin
          ramp_q <= ramp_src + 2'd1;
          dout   <= ramp_src;
        end
        default: dout <= '0;
      endcase
    end
  end

  a_off_is_zero: assert property (
    @(posedge CLK) disable iff (!RSTX)
    !en |=> (dout == '0)
  );

endmodule

`default_nettype wire

// File: rtl/result_select.sv
`timescale 1ns/1ns
`default_nettype none

module result_select (
  input  wire                                                      CLK,
  input  wire                                                      RSTX,
  input  wire  [1:0]                                               lane_sel,
  input  wire  [link_test_pkg::NUM_LANES*link_test_pkg::CNT_W-1:0] recv_all,
  input  wire  [link_test_pkg::NUM_LANES*link_test_pkg::CNT_W-1:0] err_all,
  output logic [link_test_pkg::CNT_W-1:0]                          recv_cnt,
  output logic [link_test_pkg::CNT_W-1:0]                          err_cnt,
  output logic [link_test_pkg::NUM_LANES-1:0]                      err_flags
);

  logic [link_test_pkg::CNT_W-1:0]     recv_d;
  logic [link_test_pkg::CNT_W-1:0]     err_d;
  logic [link_test_pkg::NUM_LANES-1:0] flags_d;

  always_comb begin
    recv_d = recv_all[lane_sel*link_test_pkg::CNT_W +: link_test_pkg::CNT_W];
    err_d  = err_all[lane_sel*link_test_pkg::CNT_W +: link_test_pkg::CNT_W];
    for (int i = 0; i < link_test_pkg::NUM_LANES; i++) begin
      flags_d[i] = |err_all[i*link_test_pkg::CNT_W +: link_test_pkg::CNT_W];  // Any error seen
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      recv_cnt  <= '0;
      err_cnt   <= '0;
      err_flags <= '0;
    end else begin
      recv_cnt  <= recv_d;
      err_cnt   <= err_d;
      err_flags <= flags_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/link_test_pkg.sv
rtl/mode_decoder.sv
rtl/pattern_gen.sv
rtl/pattern_check.sv
rtl/result_select.sv
rtl/link_test_top.sv
dv/link_test_tb.sv
